// ==== picoIo_config.svh ====
`ifndef PICOIO_CONFIG_SVH
`define PICOIO_CONFIG_SVH

////////////////////////////////////////
// Processor port addresses
////////////////////////////////////////
`define PA_SLSWTCH      8'h01 // Switches 7:0, read
`define PA_LEDS         8'h02 // LEDs 7:0, write
`define PA_OOB          8'h08 // Out of bounds byte from software
`define PA_LINK_STAT    8'h09 // Radio link status, read
`define PA_CURSOR_CHECK 8'h0A // Cursor and selected bank read address
`define PA_RAM_W_ADDR   8'h0B // Write address, also arms write enable
`define PA_VALID_FLAG   8'h0C // Placement check result, read
`define PA_SLSWTCH_HI   8'h11 // Switches 15:8
`define PA_LEDS_HI      8'h12 // LEDs 15:8
`define PA_RAM_SELECT   8'h13 // Bank select, bit 0
`define PA_RAM_W_VAL    8'h18 // Cell value to write
`define PA_DATA_RX      8'h19 // Received radio byte
`define PA_SHIP_CHECK_1 8'h1A // Extra us bank reads for ship placement
`define PA_SHIP_CHECK_2 8'h1B
`define PA_SHIP_CHECK_3 8'h1C
`define PA_SHIP_CHECK_4 8'h1D
`define PA_DATA_TX      8'h1E // Byte to send over radio
`define PA_DATA_RAM     8'h1F // Cell read back from selected bank

////////////////////////////////////////
// Validity codes
////////////////////////////////////////
`define OUT_OF_BOUNDS 8'hFF // Written to PA_OOB when cursor is off board
`define VALID_FLAG    8'h01
`define INVALID_FLAG  8'h00

// Board memory geometry
`define BOARD_ADDR_W 8
`define CELL_W       2

`endif

// ==== picoPortPkg.sv ====
package picoPortPkg;

	// One data byte on the processor bus
	typedef logic [7:0] byte_t;

	// Processor output side, as seen by the port block
	typedef struct packed {
		byte_t portId;      // Port address
		byte_t outPort;     // Write data
		logic  writeStrobe; // Qualifies writes only
	} hostBus_t;

	// One opcode per decoded port address
	typedef enum logic [4:0] {
		OP_NONE,
		OP_SLSWTCH,
		OP_LEDS,
		OP_OOB,
		OP_LINK_STAT,
		OP_CURSOR_CHECK,
		OP_RAM_W_ADDR,
		OP_VALID_FLAG,
		OP_SLSWTCH_HI,
		OP_LEDS_HI,
		OP_RAM_SELECT,
		OP_RAM_W_VAL,
		OP_DATA_RX,
		OP_SHIP_CHECK_1,
		OP_SHIP_CHECK_2,
		OP_SHIP_CHECK_3,
		OP_SHIP_CHECK_4,
		OP_DATA_TX,
		OP_DATA_RAM
	} portOp_t;

	// Radio status, lands in bits 7:6 of the status byte
	typedef struct packed {
		logic connEstablished;
		logic rxReadyHold; // Held until processor reads rx data
	} linkStat_t;

endpackage

// ==== boardRamPkg.sv ====
`include "picoIo_config.svh"

package boardRamPkg;

	// Board cell, 00 means empty
	typedef logic [`CELL_W-1:0] cell_t;

	// Which board the processor is talking to
	typedef enum logic {
		BANK_US   = 1'b0, // Our fleet
		BANK_THEM = 1'b1  // Our guesses
	} ramSel_t;

	// Everything one board memory needs
	typedef struct packed {
		logic [`BOARD_ADDR_W-1:0] readAddr;
		logic [`BOARD_ADDR_W-1:0] writeAddr;
		cell_t                    writeValue;
		logic                     writeEnable; // Single cycle pulse
	} ramReq_t;

endpackage

// ==== portDecode.sv ====
`timescale 1ns/1ps
`include "picoIo_config.svh"

module portDecode (
	input  picoPortPkg::byte_t   portId,
	output picoPortPkg::portOp_t op
);
	import picoPortPkg::*;

	// Pure lookup, no state
	always_comb begin
		case (portId)
			`PA_SLSWTCH:      op = OP_SLSWTCH;
			`PA_LEDS:         op = OP_LEDS;
			`PA_OOB:          op = OP_OOB;
			`PA_LINK_STAT:    op = OP_LINK_STAT;
			`PA_CURSOR_CHECK: op = OP_CURSOR_CHECK;
			`PA_RAM_W_ADDR:   op = OP_RAM_W_ADDR; // Also arms write enable
			`PA_VALID_FLAG:   op = OP_VALID_FLAG; // Also clears accumulator
			`PA_SLSWTCH_HI:   op = OP_SLSWTCH_HI;
			`PA_LEDS_HI:      op = OP_LEDS_HI;
			`PA_RAM_SELECT:   op = OP_RAM_SELECT;
			`PA_RAM_W_VAL:    op = OP_RAM_W_VAL;
			`PA_DATA_RX:      op = OP_DATA_RX;    // Also drops rx hold
			`PA_SHIP_CHECK_1: op = OP_SHIP_CHECK_1;
			`PA_SHIP_CHECK_2: op = OP_SHIP_CHECK_2;
			`PA_SHIP_CHECK_3: op = OP_SHIP_CHECK_3;
			`PA_SHIP_CHECK_4: op = OP_SHIP_CHECK_4;
			`PA_DATA_TX:      op = OP_DATA_TX;    // Also raises tx send
			`PA_DATA_RAM:     op = OP_DATA_RAM;
			default:          op = OP_NONE;       // Dropped or unused ports
		endcase
	end

endmodule

// ==== portExecute.sv ====
`timescale 1ns/1ps
`include "picoIo_config.svh"

module portExecute (
	input  logic                   clk,
	input  logic                   rstN,
	input  picoPortPkg::hostBus_t  host,
	input  picoPortPkg::portOp_t   op,
	input  boardRamPkg::cell_t     usData,
	input  boardRamPkg::cell_t     themData,
	input  logic                   rxReady,
	input  picoPortPkg::byte_t     rxData,
	input  logic                   connEstablished,
	input  logic                   intRequest,
	input  logic                   interruptAck,
	output boardRamPkg::ramReq_t   usReq,
	output boardRamPkg::ramReq_t   themReq,
	output picoPortPkg::byte_t     cursor,
	output logic [15:0]            leds,
	output picoPortPkg::byte_t     oob,
	output picoPortPkg::byte_t     txData,
	output logic                   txSend,
	output logic                   interrupt,
	output boardRamPkg::ramSel_t   bankSel,
	output picoPortPkg::linkStat_t link,
	output picoPortPkg::byte_t     rxLatch,
	output picoPortPkg::byte_t     validFlag
);
	import picoPortPkg::*;
	import boardRamPkg::*;

	logic  selUs;       // Us bank currently selected
	logic  weArm;       // Write address seen, enable fires next edge
	cell_t placeAcc;    // OR of every us cell read since last clear
	logic  accClear;    // Clear accumulator on next edge
	logic  rxReadyHold;

	assign selUs = (bankSel == BANK_US);

	////////////////////////////////////////
	// Simple processor registers
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			leds    <= '0;
			oob     <= '0;
			txData  <= '0;
			bankSel <= BANK_US;
		end else if (host.writeStrobe) begin
			case (op)
				OP_LEDS:       leds[7:0]  <= host.outPort;
				OP_LEDS_HI:    leds[15:8] <= host.outPort;
				OP_OOB:        oob        <= host.outPort;
				OP_DATA_TX:    txData     <= host.outPort; // Send flag handled below
				OP_RAM_SELECT: bankSel    <= ramSel_t'(host.outPort[0]);
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Board memory requests
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			usReq   <= '0;
			themReq <= '0;
			cursor  <= '0;
			weArm   <= 1'b0;
		end else begin
			usReq.writeEnable   <= 1'b0; // Default low, pulse only
			themReq.writeEnable <= 1'b0;
			if (weArm) begin
				weArm <= 1'b0;
				if (selUs)
					usReq.writeEnable <= 1'b1;
				else
					themReq.writeEnable <= 1'b1;
			end else if (op == OP_RAM_W_ADDR) begin
				weArm <= 1'b1; // No strobe needed to arm
			end

			if (host.writeStrobe) begin
				case (op)
					OP_CURSOR_CHECK: begin
						if (selUs)
							usReq.readAddr <= host.outPort;
						else
							themReq.readAddr <= host.outPort;
						cursor <= host.outPort; // Display follows the cursor
					end
					// Placement probes always hit our fleet
					OP_SHIP_CHECK_1, OP_SHIP_CHECK_2,
					OP_SHIP_CHECK_3, OP_SHIP_CHECK_4: usReq.readAddr <= host.outPort;
					OP_RAM_W_ADDR: begin
						if (selUs)
							usReq.writeAddr <= host.outPort;
						else
							themReq.writeAddr <= host.outPort;
					end
					OP_RAM_W_VAL: begin
						if (selUs)
							usReq.writeValue <= host.outPort[`CELL_W-1:0];
						else
							themReq.writeValue <= host.outPort[`CELL_W-1:0];
					end
					default: ;
				endcase
			end
		end
	end

	// Placement accumulator, any occupied cell spoils the spot
	always_ff @(posedge clk) begin
		if (!rstN) begin
			placeAcc <= '0;
			accClear <= 1'b0;
		end else if (op == OP_VALID_FLAG) begin
			accClear <= 1'b1; // Result being read, drop it next edge
		end else if (accClear) begin
			placeAcc <= '0;
			accClear <= 1'b0;
		end else begin
			placeAcc <= placeAcc | usData;
		end
	end

	assign validFlag = (oob != `OUT_OF_BOUNDS && placeAcc == '0) ? `VALID_FLAG : `INVALID_FLAG;

	////////////////////////////////////////
	// Radio link and interrupt
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rxLatch     <= '0;
			rxReadyHold <= 1'b0;
			txSend      <= 1'b0;
		end else begin
			if (rxReady)
				rxLatch <= rxData; // Keep last byte until next arrives
			if (rxReady)
				rxReadyHold <= 1'b1;
			else if (op == OP_DATA_RX)
				rxReadyHold <= 1'b0;
			// No busy from the radio, so hold send until the other board answers
			if (op == OP_DATA_TX)
				txSend <= 1'b1;
			else if (rxReady)
				txSend <= 1'b0;
		end
	end

	assign link = '{connEstablished: connEstablished, rxReadyHold: rxReadyHold};

	// Closed loop interrupt, ack beats request
	always_ff @(posedge clk) begin
		if (!rstN)
			interrupt <= 1'b0;
		else if (interruptAck)
			interrupt <= 1'b0;
		else if (intRequest)
			interrupt <= 1'b1;
	end

	aWeExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(usReq.writeEnable && themReq.writeEnable))
		else $error("both bank write enables high");

	aWeSingle: assert property (@(posedge clk) disable iff (!rstN)
		(usReq.writeEnable || themReq.writeEnable) |=>
		!(usReq.writeEnable || themReq.writeEnable))
		else $error("write enable high for two cycles");

	aIntAck: assert property (@(posedge clk) disable iff (!rstN)
		interruptAck |=> !interrupt)
		else $error("interrupt still high after ack");

endmodule

// ==== portResult.sv ====
`timescale 1ns/1ps

module portResult (
	input  logic                   clk,
	input  logic                   rstN,
	input  picoPortPkg::portOp_t   op,
	input  logic [15:0]            sw,
	input  logic [15:0]            leds,
	input  picoPortPkg::byte_t     cursor,
	input  picoPortPkg::byte_t     oob,
	input  picoPortPkg::byte_t     txData,
	input  picoPortPkg::byte_t     rxLatch,
	input  picoPortPkg::byte_t     validFlag,
	input  picoPortPkg::linkStat_t link,
	input  boardRamPkg::ramSel_t   bankSel,
	input  boardRamPkg::ramReq_t   usReq,
	input  boardRamPkg::ramReq_t   themReq,
	input  boardRamPkg::cell_t     usData,
	input  boardRamPkg::cell_t     themData,
	output picoPortPkg::byte_t     inPort
);
	import picoPortPkg::*;
	import boardRamPkg::*;

	ramReq_t selReq;  // Request of selected bank
	cell_t   selData; // Read data of selected bank

	assign selReq  = (bankSel == BANK_US) ? usReq : themReq;
	assign selData = (bankSel == BANK_US) ? usData : themData;

	////////////////////////////////////////
	// Registered read mux
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			inPort <= '0;
		end else begin
			case (op)
				OP_SLSWTCH:      inPort <= sw[7:0];
				OP_SLSWTCH_HI:   inPort <= sw[15:8];
				OP_LEDS:         inPort <= leds[7:0];
				OP_LEDS_HI:      inPort <= leds[15:8];
				OP_OOB:          inPort <= oob;
				OP_LINK_STAT:    inPort <= {link.connEstablished, link.rxReadyHold, 6'b0};
				OP_CURSOR_CHECK: inPort <= selReq.readAddr;
				OP_RAM_W_ADDR:   inPort <= selReq.writeAddr;
				OP_VALID_FLAG:   inPort <= validFlag;
				OP_RAM_SELECT:   inPort <= {7'b0, bankSel};
				OP_RAM_W_VAL:    inPort <= {6'b0, selReq.writeValue};
				OP_DATA_RX:      inPort <= rxLatch;
				// Ship checks echo the cursor
				OP_SHIP_CHECK_1, OP_SHIP_CHECK_2,
				OP_SHIP_CHECK_3, OP_SHIP_CHECK_4: inPort <= cursor;
				OP_DATA_TX:      inPort <= txData;
				OP_DATA_RAM:     inPort <= {6'b0, selData};
				default:         inPort <= '0; // OP_NONE
			endcase
		end
	end

endmodule

// ==== picoIoTop.sv ====
`timescale 1ns/1ps

module picoIoTop (
	input  logic                  clk,
	input  logic                  rstN,
	input  picoPortPkg::hostBus_t host,
	input  logic [15:0]           sw,
	input  boardRamPkg::cell_t    usData,
	input  boardRamPkg::cell_t    themData,
	input  logic                  rxReady,
	input  picoPortPkg::byte_t    rxData,
	input  logic                  connEstablished,
	input  logic                  intRequest,
	input  logic                  interruptAck,
	output picoPortPkg::byte_t    inPort,
	output boardRamPkg::ramReq_t  usReq,
	output boardRamPkg::ramReq_t  themReq,
	output picoPortPkg::byte_t    cursor,
	output logic [15:0]           leds,
	output logic                  txSend,
	output picoPortPkg::byte_t    txData,
	output logic                  interrupt
);
	import picoPortPkg::*;
	import boardRamPkg::*;

	portOp_t   op;        // Shared by execute and result
	byte_t     oob;
	byte_t     rxLatch;
	byte_t     validFlag;
	ramSel_t   bankSel;
	linkStat_t link;

	portDecode i_decode (
		.portId (host.portId),
		.op     (op)
	);

	portExecute i_execute (
		.clk             (clk),
		.rstN            (rstN),
		.host            (host),
		.op              (op),
		.usData          (usData),
		.themData        (themData),
		.rxReady         (rxReady),
		.rxData          (rxData),
		.connEstablished (connEstablished),
		.intRequest      (intRequest),
		.interruptAck    (interruptAck),
		.usReq           (usReq),
		.themReq         (themReq),
		.cursor          (cursor),
		.leds            (leds),
		.oob             (oob),
		.txData          (txData),
		.txSend          (txSend),
		.interrupt       (interrupt),
		.bankSel         (bankSel),
		.link            (link),
		.rxLatch         (rxLatch),
		.validFlag       (validFlag)
	);

	portResult i_result (
		.clk       (clk),
		.rstN      (rstN),
		.op        (op),
		.sw        (sw),
		.leds      (leds),
		.cursor    (cursor),
		.oob       (oob),
		.txData    (txData),
		.rxLatch   (rxLatch),
		.validFlag (validFlag),
		.link      (link),
		.bankSel   (bankSel),
		.usReq     (usReq),
		.themReq   (themReq),
		.usData    (usData),
		.themData  (themData),
		.inPort    (inPort)
	);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);
	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for three rising edges
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== tbPicoIo.sv ====
`timescale 1ns/1ps
`include "picoIo_config.svh"

module tbPicoIo;
	import picoPortPkg::*;
	import boardRamPkg::*;

	logic        clk;
	logic        rstN;
	hostBus_t    host;
	logic [15:0] sw;
	cell_t       usData;
	cell_t       themData;
	logic        rxReady;
	byte_t       rxData;
	logic        connEstablished;
	logic        intRequest;
	logic        interruptAck;
	byte_t       inPort;
	ramReq_t     usReq;
	ramReq_t     themReq;
	byte_t       cursor;
	logic [15:0] leds;
	logic        txSend;
	byte_t       txData;
	logic        interrupt;

	cell_t       usMem [256];   // Our fleet
	cell_t       themMem [256]; // Our guesses
	int          errors;
	int          errStart;
	int          testNum;

	// Reference model state
	logic [15:0] mLeds;
	byte_t       mOob;
	byte_t       mTx;
	byte_t       mCursor;
	byte_t       mRx;
	byte_t       mIn;      // Expected inPort
	logic        mSel;     // 1 selects guess board
	ramReq_t     mUs;
	ramReq_t     mThem;
	logic        mArm;
	logic        mClr;
	cell_t       mAcc;
	logic        mHold;
	logic        mTxSend;
	logic        mInt;

	tbClock i_clock (.clk(clk), .rstN(rstN));
	picoIoTop i_dut (.*);

	////////////////////////////////////////
	// Board memories
	////////////////////////////////////////
	assign usData   = usMem[usReq.readAddr];     // Combinational read
	assign themData = themMem[themReq.readAddr];

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 256; i++) begin
				// Fill from every address bit
				usMem[i]   <= cell_t'(i[7:6] ^ i[5:4] ^ i[3:2] ^ i[1:0]);
				themMem[i] <= {i[7] ^ i[4] ^ i[2] ^ i[0], i[6] ^ i[5] ^ i[3] ^ i[1]};
			end
		end else begin
			if (usReq.writeEnable)
				usMem[usReq.writeAddr] <= usReq.writeValue;
			if (themReq.writeEnable)
				themMem[themReq.writeAddr] <= themReq.writeValue;
		end
	end

	////////////////////////////////////////
	// Cycle model of the port block
	////////////////////////////////////////
	function automatic byte_t expectedRead(input byte_t addr);
		ramReq_t sel;
		cell_t   data;
		sel  = mSel ? mThem : mUs;
		data = mSel ? themData : usData;
		case (addr)
			`PA_SLSWTCH:      return sw[7:0];
			`PA_SLSWTCH_HI:   return sw[15:8];
			`PA_LEDS:         return mLeds[7:0];
			`PA_LEDS_HI:      return mLeds[15:8];
			`PA_OOB:          return mOob;
			`PA_LINK_STAT:    return {connEstablished, mHold, 6'b0};
			`PA_CURSOR_CHECK: return sel.readAddr;
			`PA_RAM_W_ADDR:   return sel.writeAddr;
			`PA_VALID_FLAG:
				return (mOob != `OUT_OF_BOUNDS && mAcc == '0) ? `VALID_FLAG : `INVALID_FLAG;
			`PA_RAM_SELECT:   return {7'b0, mSel};
			`PA_RAM_W_VAL:    return {6'b0, sel.writeValue};
			`PA_DATA_RX:      return mRx;
			`PA_SHIP_CHECK_1, `PA_SHIP_CHECK_2,
			`PA_SHIP_CHECK_3, `PA_SHIP_CHECK_4: return mCursor;
			`PA_DATA_TX:      return mTx;
			`PA_DATA_RAM:     return {6'b0, data};
			default:          return 8'h00;
		endcase
	endfunction

	always @(posedge clk) begin
		if (!rstN) begin
			mLeds   <= '0;
			mOob    <= '0;
			mTx     <= '0;
			mCursor <= '0;
			mRx     <= '0;
			mIn     <= '0;
			mSel    <= 1'b0;
			mUs     <= '0;
			mThem   <= '0;
			mArm    <= 1'b0;
			mClr    <= 1'b0;
			mAcc    <= '0;
			mHold   <= 1'b0;
			mTxSend <= 1'b0;
			mInt    <= 1'b0;
		end else begin
			mIn               <= expectedRead(host.portId);
			mArm              <= !mArm && host.portId == `PA_RAM_W_ADDR; // Every other cycle at most
			mUs.writeEnable   <= mArm && !mSel;
			mThem.writeEnable <= mArm && mSel;
			mClr              <= host.portId == `PA_VALID_FLAG;
			if (host.portId != `PA_VALID_FLAG)
				mAcc <= mClr ? '0 : (mAcc | usData); // Held while the flag is read
			if (rxReady) begin
				mRx   <= rxData;
				mHold <= 1'b1;
			end else if (host.portId == `PA_DATA_RX) begin
				mHold <= 1'b0;
			end
			mTxSend <= host.portId == `PA_DATA_TX || (mTxSend && !rxReady);
			mInt    <= !interruptAck && (mInt || intRequest); // Ack first
			if (host.writeStrobe) begin
				case (host.portId)
					`PA_LEDS:       mLeds[7:0]  <= host.outPort;
					`PA_LEDS_HI:    mLeds[15:8] <= host.outPort;
					`PA_OOB:        mOob        <= host.outPort;
					`PA_DATA_TX:    mTx         <= host.outPort;
					`PA_RAM_SELECT: mSel        <= host.outPort[0];
					`PA_CURSOR_CHECK: begin
						mCursor <= host.outPort;
						if (mSel)
							mThem.readAddr <= host.outPort;
						else
							mUs.readAddr <= host.outPort;
					end
					`PA_SHIP_CHECK_1, `PA_SHIP_CHECK_2,
					`PA_SHIP_CHECK_3, `PA_SHIP_CHECK_4: mUs.readAddr <= host.outPort;
					`PA_RAM_W_ADDR: begin
						if (mSel)
							mThem.writeAddr <= host.outPort;
						else
							mUs.writeAddr <= host.outPort;
					end
					`PA_RAM_W_VAL: begin
						if (mSel)
							mThem.writeValue <= host.outPort[1:0];
						else
							mUs.writeValue <= host.outPort[1:0];
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic checkByte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkReq(input string name, input ramReq_t got, input ramReq_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %05h expected %05h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkCell(input string name, input cell_t got, input cell_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Whole DUT against the model, at the falling edge
	task automatic compareAll();
		checkByte("inPort", inPort, mIn);
		checkReq("usReq", usReq, mUs);
		checkReq("themReq", themReq, mThem);
		checkByte("cursor", cursor, mCursor);
		checkByte("leds[7:0]", leds[7:0], mLeds[7:0]);
		checkByte("leds[15:8]", leds[15:8], mLeds[15:8]);
		checkByte("txData", txData, mTx);
		checkBit("txSend", txSend, mTxSend);
		checkBit("interrupt", interrupt, mInt);
	endtask

	////////////////////////////////////////
	// Bus helpers
	////////////////////////////////////////
	task automatic busCycle(input byte_t addr, input byte_t data, input logic strobe);
		@(posedge clk);
		host <= {addr, data, strobe};
		@(negedge clk);
		compareAll();
	endtask

	// Idle bus cycle that also moves the side inputs
	task automatic sideInputs(input logic [15:0] s, input logic conn, input logic req,
		input logic ack);
		@(posedge clk);
		host            <= '0;
		sw              <= s;
		connEstablished <= conn;
		intRequest      <= req;
		interruptAck    <= ack;
		@(negedge clk);
		compareAll();
	endtask

	task automatic readPort(input byte_t addr, output byte_t val);
		busCycle(addr, 8'h00, 1'b0);
		busCycle(8'h00, 8'h00, 1'b0); // inPort is one edge behind
		val = inPort;
	endtask

	task automatic pulseRx(input byte_t data);
		@(posedge clk);
		host    <= '0;
		rxReady <= 1'b1;
		rxData  <= data;
		@(negedge clk);
		compareAll();
		@(posedge clk);
		rxReady <= 1'b0;
		@(negedge clk);
		compareAll();
	endtask

	// Select, value, address, then wait for the enable pulse
	task automatic writeCell(input logic bank, input cell_t value, input byte_t addr,
		output int edges);
		logic seen;
		busCycle(`PA_RAM_SELECT, {7'b0, bank}, 1'b1);
		busCycle(`PA_RAM_W_VAL, {6'b0, value}, 1'b1);
		busCycle(`PA_RAM_W_ADDR, addr, 1'b1);
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges < 6) begin
			busCycle(8'h00, 8'h00, 1'b0);
			edges++;
			seen = bank ? themReq.writeEnable : usReq.writeEnable;
			checkBit("unselected writeEnable",
				bank ? usReq.writeEnable : themReq.writeEnable, 1'b0);
		end
		if (!seen) begin
			$display("timeout: no write enable on bank %0d for address %02h", bank, addr);
			errors++;
		end
		busCycle(8'h00, 8'h00, 1'b0); // Memory takes the cell here
	endtask

	task automatic endTest(input string name);
		testNum++;
		$display("test %0d %s finished with %0d errors", testNum, name, errors - errStart);
		errStart = errors;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic testLedsSwitches();
		byte_t       v;
		byte_t       got;
		logic [15:0] s;
		for (int i = 0; i < 8; i++) begin
			v = byte_t'($urandom);
			busCycle(`PA_LEDS, v, 1'b1);
			readPort(`PA_LEDS, got);
			checkByte("PA_LEDS readback", got, v);
			v = byte_t'($urandom);
			busCycle(`PA_LEDS_HI, v, 1'b1);
			readPort(`PA_LEDS_HI, got);
			checkByte("PA_LEDS_HI readback", got, v);
			s = 16'($urandom);
			sideInputs(s, connEstablished, 1'b0, 1'b0);
			readPort(`PA_SLSWTCH, got);
			checkByte("PA_SLSWTCH", got, s[7:0]);
			readPort(`PA_SLSWTCH_HI, got);
			checkByte("PA_SLSWTCH_HI", got, s[15:8]);
		end
		endTest("leds and switches");
	endtask

	task automatic testBoardWrite();
		logic  b;
		cell_t v;
		byte_t a;
		byte_t got;
		int    edges;
		for (int i = 0; i < 8; i++) begin
			b = 1'($urandom);
			v = cell_t'($urandom);
			a = byte_t'($urandom);
			writeCell(b, v, a, edges);
			checkByte("writeEnable delay", byte_t'(edges), 8'd2); // Second edge after address
			checkCell("memory cell", b ? themMem[a] : usMem[a], v);
			busCycle(`PA_CURSOR_CHECK, a, 1'b1);
			readPort(`PA_DATA_RAM, got);
			checkByte("PA_DATA_RAM", got, {6'b0, v});
		end
		endTest("board write");
	endtask

	task automatic testReadAddr();
		logic  b;
		byte_t a;
		byte_t c;
		byte_t shipAddr;
		byte_t got;
		byte_t prevUs;
		byte_t prevThem;
		for (int i = 0; i < 8; i++) begin
			b = 1'($urandom);
			a = byte_t'($urandom);
			c = byte_t'($urandom);
			shipAddr = byte_t'(`PA_SHIP_CHECK_1 + $urandom % 4);
			busCycle(`PA_RAM_SELECT, {7'b0, b}, 1'b1);
			prevUs   = mUs.readAddr;
			prevThem = mThem.readAddr;
			busCycle(`PA_CURSOR_CHECK, a, 1'b1);
			busCycle(8'h00, 8'h00, 1'b0);
			checkByte("cursor", cursor, a);
			checkByte("usReq.readAddr", usReq.readAddr, b ? prevUs : a);
			checkByte("themReq.readAddr", themReq.readAddr, b ? a : prevThem);
			busCycle(shipAddr, c, 1'b1); // Only the us bank moves
			busCycle(8'h00, 8'h00, 1'b0);
			checkByte("usReq.readAddr", usReq.readAddr, c);
			checkByte("themReq.readAddr", themReq.readAddr, b ? a : prevThem);
			readPort(shipAddr, got);
			checkByte("ship check readback", got, a);
		end
		endTest("read addresses");
	endtask

	task automatic testPlacement();
		byte_t addrs [4];
		cell_t occ;
		cell_t cellVal;
		byte_t oobv;
		byte_t empty;
		byte_t got;
		int    edges;
		for (int i = 0; i < 8; i++) begin
			occ = '0;
			for (int j = 0; j < 4; j++) begin
				addrs[j] = byte_t'($urandom);
				cellVal  = ($urandom % 4 == 0) ? cell_t'(1 + $urandom % 3) : 2'b00;
				writeCell(1'b0, cellVal, addrs[j], edges);
			end
			for (int j = 0; j < 4; j++)
				occ = occ | usMem[addrs[j]];
			empty = 8'h00;
			for (int k = 255; k >= 0; k--)
				if (usMem[k] == '0)
					empty = byte_t'(k);
			oobv = ($urandom % 4 == 0) ? `OUT_OF_BOUNDS : byte_t'($urandom);
			busCycle(`PA_SHIP_CHECK_1, addrs[0], 1'b1);
			readPort(`PA_VALID_FLAG, got); // Start from a clean accumulator
			busCycle(8'h00, 8'h00, 1'b0);
			busCycle(`PA_SHIP_CHECK_2, addrs[1], 1'b1);
			busCycle(`PA_SHIP_CHECK_3, addrs[2], 1'b1);
			busCycle(`PA_SHIP_CHECK_4, addrs[3], 1'b1);
			busCycle(`PA_OOB, oobv, 1'b1);
			busCycle(`PA_SHIP_CHECK_1, empty, 1'b1); // Park on an empty cell
			readPort(`PA_VALID_FLAG, got);
			checkByte("PA_VALID_FLAG",
				got, (oobv != `OUT_OF_BOUNDS && occ == '0) ? `VALID_FLAG : `INVALID_FLAG);
			readPort(`PA_VALID_FLAG, got);
			checkByte("PA_VALID_FLAG after clear",
				got, (oobv != `OUT_OF_BOUNDS) ? `VALID_FLAG : `INVALID_FLAG);
		end
		endTest("placement validity");
	endtask

	task automatic testRadio();
		byte_t d;
		byte_t t;
		byte_t got;
		logic  conn;
		int    n;
		for (int i = 0; i < 8; i++) begin
			d    = byte_t'($urandom);
			t    = byte_t'($urandom);
			conn = 1'($urandom);
			sideInputs(sw, conn, 1'b0, 1'b0);
			repeat ($urandom % 4) busCycle(8'h00, 8'h00, 1'b0);
			pulseRx(d);
			readPort(`PA_LINK_STAT, got);
			checkByte("link status", got, {conn, 1'b1, 6'b0});
			readPort(`PA_DATA_RX, got);
			checkByte("PA_DATA_RX", got, d);
			readPort(`PA_LINK_STAT, got);
			checkByte("link status after rx read", got, {conn, 1'b0, 6'b0});
			busCycle(`PA_DATA_TX, t, 1'b1);
			busCycle(8'h00, 8'h00, 1'b0);
			checkBit("txSend", txSend, 1'b1);
			checkByte("txData", txData, t);
			pulseRx(byte_t'($urandom)); // Answer from the other board
			n = 0;
			while (txSend && n < 8) begin
				busCycle(8'h00, 8'h00, 1'b0);
				n++;
			end
			if (txSend) begin
				$display("timeout: txSend still high after the answer pulse");
				errors++;
			end
		end
		endTest("radio link");
	endtask

	task automatic testInterrupt();
		int n;
		for (int i = 0; i < 8; i++) begin
			repeat ($urandom % 4) busCycle(8'h00, 8'h00, 1'b0);
			sideInputs(sw, connEstablished, 1'b1, 1'b0);
			n = 0;
			while (!interrupt && n < 8) begin
				sideInputs(sw, connEstablished, 1'b0, 1'b0);
				n++;
			end
			if (!interrupt) begin
				$display("timeout: interrupt never rose after the request");
				errors++;
			end
			repeat (1 + $urandom % 4) sideInputs(sw, connEstablished, 1'b0, 1'b0);
			checkBit("interrupt held", interrupt, 1'b1);
			sideInputs(sw, connEstablished, 1'b0, 1'b1);
			sideInputs(sw, connEstablished, 1'b0, 1'b0);
			checkBit("interrupt after ack", interrupt, 1'b0);
			sideInputs(sw, connEstablished, 1'b1, 1'b1); // Ack beats request
			sideInputs(sw, connEstablished, 1'b0, 1'b0);
			checkBit("interrupt with request and ack", interrupt, 1'b0);
		end
		endTest("interrupt");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		int n;
		host            = '0;
		sw              = '0;
		rxReady         = 1'b0;
		rxData          = '0;
		connEstablished = 1'b0;
		intRequest      = 1'b0;
		interruptAck    = 1'b0;
		errors          = 0;
		errStart        = 0;
		testNum         = 0;
		void'($urandom(32'h3588_0b3f));
		n = 0;
		while (rstN !== 1'b1 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (rstN !== 1'b1) begin
			$display("reset was never released");
			errors++;
		end
		testLedsSwitches();
		testBoardWrite();
		testReadAddr();
		testPlacement();
		testRadio();
		testInterrupt();
		$display("%0d tests run, %0d checks failed", testNum, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
picoPortPkg.sv
boardRamPkg.sv
portDecode.sv
portExecute.sv
portResult.sv
picoIoTop.sv
tbClock.sv
tbPicoIo.sv

// ==== Makefile ====
# Verilator flow for the picoIo port block

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tbPicoIo with Verilator, run it, check run.log"
	@echo "  clean  remove obj_dir and run.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tbPicoIo -f flist.f -o tbPicoIo
	./obj_dir/tbPicoIo | tee run.log
	@if grep -q "TEST PASS" run.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
